// ==== cpu_top.f ====
rtl/cpu_pkg.sv
rtl/alu.sv
rtl/reg_file.sv
rtl/datapath.sv
rtl/controller.sv
rtl/hazard.sv
rtl/cpu_top.sv
verification/cpu_top_props.sv
verification/tb_cpu_top.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the cpu_top testbench with Verilator
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert --top-module tb_cpu_top -f cpu_top.f
./obj_dir/Vtb_cpu_top | tee sim.log
if grep -qx "Everything OK" sim.log; then
  echo "simulation passed"
else
  echo "simulation failed"
  exit 1
fi

// ==== verification/tb_cpu_top.sv ====
`timescale 1ns/1ps

module tb_cpu_top;
  import cpu_pkg::*;

  localparam int num_progs = 6;
  localparam int prog_len = 40;
  // body plus seven final stores plus the closing jal
  localparam int body_len = prog_len - 8;
  localparam int reset_cycles = 16;
  localparam int drain_cycles = 8;
  localparam int cycle_limit = num_progs * (3 * prog_len + 20);
  localparam logic [31:0] reset_pc = 32'h0;

  logic        clk;
  logic        rst_n;
  logic [31:0] imem_addr;
  logic [31:0] imem_data;
  logic [31:0] dmem_rdata;
  dmem_req_t   dmem;

  logic [31:0] imem [256];
  logic [31:0] dmem_mem [64];
  logic [31:0] model_mem [64];
  logic [31:0] exp_addr [$];
  logic [31:0] exp_data [$];
  logic [31:0] seed;
  int          cycles;
  int          idle;

  // both memories answer in the same cycle
  assign imem_data  = imem[imem_addr[9:2]];
  assign dmem_rdata = dmem_mem[dmem.addr[7:2]];

  cpu_top #(.reset_pc(reset_pc)) u_cpu_top (
    .clk, .rst_n, .imem_addr, .imem_data, .dmem, .dmem_rdata
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  function automatic logic [31:0] next_rand();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed;
  endfunction

  function automatic int pick_below(input int n);
    return int'((next_rand() >> 8) % 32'(n));
  endfunction

  function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3,
                                         input logic [4:0] rd, input logic [6:0] opc);
    return {f7, rs2, rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                         input logic [2:0] f3, input logic [4:0] rd,
                                         input logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] s_type(input logic [11:0] imm, input logic [4:0] rs2,
                                         input logic [4:0] rs1);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
  endfunction

  function automatic logic [31:0] b_type(input logic [12:0] imm, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
  endfunction

  function automatic logic [31:0] j_type(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
  endfunction

  // reference behaviour of the RV32I integer operations
  function automatic logic [31:0] alu_result(input logic [2:0] f3, input logic alt,
                                             input logic [31:0] a, input logic [31:0] b);
    case (f3)
      3'b000:  return alt ? a - b : a + b;
      3'b001:  return a << b[4:0];
      3'b010:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'b011:  return (a < b) ? 32'd1 : 32'd0;
      3'b100:  return a ^ b;
      3'b101:  return alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
      3'b110:  return a | b;
      default: return a & b;
    endcase
  endfunction

  function automatic logic branch_taken(input logic [2:0] f3, input logic [31:0] a,
                                        input logic [31:0] b);
    case (f3)
      3'b000:  return a == b;
      3'b001:  return a != b;
      3'b100:  return $signed(a) < $signed(b);
      3'b101:  return $signed(a) >= $signed(b);
      3'b110:  return a < b;
      3'b111:  return a >= b;
      default: return 1'b0;
    endcase
  endfunction

  task automatic stop_on_failure();
    $display("Something failed");
    $fatal(1);
  endtask

  task automatic report_error(input string msg);
    $display("ERROR %s", msg);
    stop_on_failure();
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("CHECK FAILED %s got 0x%08h expected 0x%08h", name, got, exp);
      stop_on_failure();
    end
  endtask

  task automatic build_program();
    int          idx;
    int          kind;
    int          k;
    int          reach;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [2:0]  f3;
    logic [11:0] imm;
    logic [11:0] off;
    logic        alt;
    logic [31:0] t_addr;
    for (int i = 0; i < 256; i++) begin
      imem[i] = 32'h0000_0013;
    end
    idx = 0;
    reach = 0;
    while (idx < body_len) begin
      kind = pick_below(16);
      rd = 5'(1 + pick_below(7));
      rs1 = 5'(pick_below(8));
      rs2 = 5'(pick_below(8));
      f3 = 3'(pick_below(8));
      imm = 12'(next_rand() >> 4);
      off = 12'(pick_below(64) * 4);
      alt = pick_below(2) == 1;
      k = 1 + pick_below(3);
      // jumps need room for the skipped slots and the target
      if (kind >= 12 && idx + k + 3 > body_len) begin
        kind = 0;
      end
      // a pending jump target must not land inside a lui/addi/jalr group
      if (kind == 15 && reach > idx) begin
        kind = 0;
      end
      if (kind <= 4) begin
        imem[idx] = r_type({1'b0, alt && (f3 == 3'b000 || f3 == 3'b101), 5'b0},
                           rs2, rs1, f3, rd, 7'b0110011);
      end else if (kind <= 7) begin
        if (f3 == 3'b001 || f3 == 3'b101) begin
          imm = {1'b0, alt && f3 == 3'b101, 5'b0, imm[4:0]};
        end
        imem[idx] = i_type(imm, rs1, f3, rd, 7'b0010011);
      end else if (kind == 8) begin
        imem[idx] = {20'(next_rand()), rd, 7'b0110111};
      end else if (kind <= 10) begin
        imem[idx] = i_type(off, 5'd0, 3'b010, rd, 7'b0000011);
      end else if (kind == 11) begin
        imem[idx] = s_type(off, rs2, 5'd0);
      end else if (kind <= 13) begin
        if (f3 == 3'b010 || f3 == 3'b011) begin
          f3 = f3 + 3'd2;
        end
        imem[idx] = b_type(13'(4 * (k + 1)), rs2, rs1, f3);
        reach = (idx + k + 1 > reach) ? idx + k + 1 : reach;
      end else if (kind == 14) begin
        imem[idx] = j_type(21'(4 * (k + 1)), rs1);
        reach = (idx + k + 1 > reach) ? idx + k + 1 : reach;
      end else begin
        // lui and addi build the absolute target for jalr
        t_addr = reset_pc + 32'(4 * (idx + 3 + k));
        imem[idx] = {20'((t_addr + 32'h800) >> 12), rd, 7'b0110111};
        imem[idx + 1] = i_type(t_addr[11:0], rd, 3'b000, rd, 7'b0010011);
        imem[idx + 2] = i_type(12'h000, rd, 3'b000, rs1, 7'b1100111);
        reach = idx + 3 + k;
        idx += 2;
      end
      idx++;
    end
    for (int r = 1; r < 8; r++) begin
      imem[idx] = s_type(12'(4 * (56 + r)), 5'(r), 5'd0);
      idx++;
    end
    imem[idx] = j_type(21'd0, 5'd0);
  endtask

  task automatic load_data();
    logic [31:0] salt;
    salt = next_rand();
    for (int i = 0; i < 64; i++) begin
      dmem_mem[i] = {~16'(i * 4), 16'(i * 4)} ^ salt;
      model_mem[i] = dmem_mem[i];
    end
  endtask

  // instruction-level run of the program, records every store in order
  task automatic run_model();
    logic [31:0] rf [32];
    logic [31:0] pc;
    logic [31:0] nxt;
    logic [31:0] inst;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] res;
    logic [31:0] addr;
    logic [31:0] imm_i;
    logic [31:0] imm_s;
    logic [31:0] imm_b;
    logic [31:0] imm_j;
    logic [2:0]  f3;
    logic        wr;
    int          steps;
    for (int r = 0; r < 32; r++) begin
      rf[r] = '0;
    end
    pc = reset_pc;
    steps = 0;
    inst = imem[pc[9:2]];
    while (inst != 32'h0000_006f && steps < 1000) begin
      f3 = inst[14:12];
      a = rf[inst[19:15]];
      b = rf[inst[24:20]];
      imm_i = {{20{inst[31]}}, inst[31:20]};
      imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
      imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
      imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
      nxt = pc + 32'd4;
      res = '0;
      wr = 1'b1;
      case (inst[6:0])
        7'b0110011: res = alu_result(f3, inst[30], a, b);
        7'b0010011: res = alu_result(f3, inst[30] && f3 == 3'b101, a, imm_i);
        7'b0110111: res = {inst[31:12], 12'h000};
        7'b0000011: begin
          addr = a + imm_i;
          res = model_mem[addr[7:2]];
        end
        7'b0100011: begin
          addr = a + imm_s;
          model_mem[addr[7:2]] = b;
          exp_addr.push_back(addr);
          exp_data.push_back(b);
          wr = 1'b0;
        end
        7'b1100011: begin
          if (branch_taken(f3, a, b)) begin
            nxt = pc + imm_b;
          end
          wr = 1'b0;
        end
        7'b1101111: begin
          res = pc + 32'd4;
          nxt = pc + imm_j;
        end
        7'b1100111: begin
          res = pc + 32'd4;
          nxt = (a + imm_i) & ~32'd1;
        end
        default: wr = 1'b0;
      endcase
      if (wr && inst[11:7] != 5'd0) begin
        rf[inst[11:7]] = res;
      end
      pc = nxt;
      steps++;
      inst = imem[pc[9:2]];
    end
    if (steps >= 1000) begin
      report_error("model never reached the closing jump");
    end
  endtask

  // one clock cycle, with store checking and the run limit
  task automatic watch_cycle();
    @(negedge clk);
    if (rst_n) begin
      cycles++;
    end
    if (cycles > cycle_limit) begin
      report_error("timeout, the DUT did not produce all expected stores");
    end
    if (dmem.req && dmem.write) begin
      if (exp_addr.size() == 0) begin
        report_error("store seen that the model does not perform");
      end
      check_value("dmem.addr", dmem.addr, exp_addr[0]);
      check_value("dmem.wdata", dmem.wdata, exp_data[0]);
      void'(exp_addr.pop_front());
      void'(exp_data.pop_front());
      dmem_mem[dmem.addr[7:2]] = dmem.wdata;
    end
  endtask

  initial begin
    rst_n = 1'b0;
    seed = 32'h67ee_8c35;
    cycles = 0;
    for (int p = 0; p < num_progs; p++) begin
      rst_n = 1'b0;
      build_program();
      load_data();
      run_model();
      repeat (reset_cycles) begin
        watch_cycle();
        check_value("imem_addr", imem_addr, reset_pc);
        check_value("dmem.req", 32'(dmem.req), 32'd0);
      end
      rst_n = 1'b1;
      check_value("imem_addr", imem_addr, reset_pc);
      // nothing reaches the memory stage this early
      repeat (2) begin
        watch_cycle();
        check_value("dmem.req", 32'(dmem.req), 32'd0);
      end
      idle = 0;
      while (exp_addr.size() != 0 || idle < drain_cycles) begin
        watch_cycle();
        if (exp_addr.size() == 0) begin
          idle++;
        end
      end
    end
    $display("Everything OK");
    $finish;
  end

endmodule

// ==== verification/cpu_top_props.sv ====
`timescale 1ns/1ps

module cpu_top_props (
  input logic                  clk,
  input logic                  rst_n,
  input cpu_pkg::dmem_req_t    dmem,
  input cpu_pkg::hazard_ctrl_t hz
);

  // memory stage holds a bubble once reset has been seen
  req_low_after_reset: assert property (@(posedge clk) !rst_n |=> !dmem.req)
    else $error("dmem.req high in the cycle after reset");

  write_needs_req: assert property (@(posedge clk) disable iff (!rst_n)
    dmem.write |-> dmem.req)
    else $error("dmem.write without dmem.req");

  // load-use bubble clears the load from execute
  stall_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
    hz.stall_d |=> !hz.stall_d)
    else $error("decode stalled for two consecutive cycles");

  no_flush_with_stall: assert property (@(posedge clk) disable iff (!rst_n)
    !(hz.flush_d && hz.stall_d))
    else $error("flush_d and stall_d high together");

endmodule

bind cpu_top cpu_top_props u_cpu_top_props (
  .clk   (clk),
  .rst_n (rst_n),
  .dmem  (dmem),
  .hz    (hz)
);

// ==== rtl/cpu_top.sv ====
`timescale 1ns/1ps

module cpu_top #(
  parameter logic [31:0] reset_pc = 32'h0
) (
  input  logic                      clk,
  input  logic                      rst_n,
  output logic [cpu_pkg::xlen-1:0]  imem_addr,
  input  logic [cpu_pkg::xlen-1:0]  imem_data,
  output cpu_pkg::dmem_req_t        dmem,
  input  logic [cpu_pkg::xlen-1:0]  dmem_rdata
);
  import cpu_pkg::*;

  // datapath to controller
  inst_u           inst_d;
  logic            alu_zero;
  logic            alu_lt;
  logic            alu_ltu;
  // controller to datapath
  imm_sel_e        imm_sel;
  ex_ctrl_t        ex_ctrl;
  pc_sel_e         pc_sel;
  mem_ctrl_t       mem_ctrl;
  wb_ctrl_t        wb_ctrl;
  // hazard unit in and out
  stage_regs_t     regs;
  hazard_ctrl_t    hz;
  // data memory port pieces
  logic [xlen-1:0] dmem_addr;
  logic [xlen-1:0] dmem_wdata;
  logic            dmem_req;
  logic            dmem_write;

  assign dmem = '{addr: dmem_addr, wdata: dmem_wdata, req: dmem_req, write: dmem_write};

  datapath #(.reset_pc(reset_pc)) u_datapath (
    .clk, .rst_n,
    .imem_addr, .imem_data,
    .dmem_addr, .dmem_wdata, .dmem_rdata,
    .imm_sel, .ex_ctrl, .pc_sel, .mem_ctrl, .wb_ctrl, .hz,
    .inst_d, .alu_zero, .alu_lt, .alu_ltu, .regs
  );

  controller u_controller (
    .clk, .rst_n,
    .inst_d, .alu_zero, .alu_lt, .alu_ltu, .hz,
    .imm_sel, .ex_ctrl, .pc_sel, .mem_ctrl, .wb_ctrl,
    .dmem_req, .dmem_write
  );

  hazard u_hazard (
    .regs,
    .mem_read_e  (ex_ctrl.mem_read),
    .reg_write_m (mem_ctrl.reg_write),
    .reg_write_w (wb_ctrl.reg_write),
    .pc_sel,
    .hz
  );

endmodule

// ==== rtl/hazard.sv ====
`timescale 1ns/1ps

module hazard (
  input  cpu_pkg::stage_regs_t   regs,
  input  logic                   mem_read_e,
  input  logic                   reg_write_m,
  input  logic                   reg_write_w,
  input  cpu_pkg::pc_sel_e       pc_sel,
  output cpu_pkg::hazard_ctrl_t  hz
);
  import cpu_pkg::*;

  logic load_use;
  logic redirect;

  // memory stage is younger, so it wins over writeback
  function automatic fwd_sel_e fwd_for(input reg_addr_t rs, input reg_addr_t rd_m,
                                       input logic we_m, input reg_addr_t rd_w,
                                       input logic we_w);
    if (rs == 5'd0) begin
      return fwd_none;
    end else if (we_m && rd_m == rs) begin
      return fwd_from_mem;
    end else if (we_w && rd_w == rs) begin
      return fwd_from_wb;
    end
    return fwd_none;
  endfunction

  // load result not ready until writeback
  assign load_use = mem_read_e && regs.rd_e != 5'd0 &&
                    (regs.rd_e == regs.rs1_d || regs.rd_e == regs.rs2_d);

  assign redirect = (pc_sel != pc_seq);

  always_comb begin
    hz.fwd_a   = fwd_for(regs.rs1_e, regs.rd_m, reg_write_m, regs.rd_w, reg_write_w);
    hz.fwd_b   = fwd_for(regs.rs2_e, regs.rd_m, reg_write_m, regs.rd_w, reg_write_w);
    hz.stall_f = load_use;
    hz.stall_d = load_use;
    // taken branch or jump kills decode and execute
    hz.flush_d = redirect;
    hz.flush_e = load_use || redirect;
  end

endmodule

// ==== rtl/controller.sv ====
`timescale 1ns/1ps

module controller (
  input  logic                   clk,
  input  logic                   rst_n,
  input  cpu_pkg::inst_u         inst_d,
  input  logic                   alu_zero,
  input  logic                   alu_lt,
  input  logic                   alu_ltu,
  input  cpu_pkg::hazard_ctrl_t  hz,
  output cpu_pkg::imm_sel_e      imm_sel,
  output cpu_pkg::ex_ctrl_t      ex_ctrl,
  output cpu_pkg::pc_sel_e       pc_sel,
  output cpu_pkg::mem_ctrl_t     mem_ctrl,
  output cpu_pkg::wb_ctrl_t      wb_ctrl,
  output logic                   dmem_req,
  output logic                   dmem_write
);
  import cpu_pkg::*;

  ex_ctrl_t ctrl_d;
  logic     alt_d;
  logic     taken;

  function automatic alu_op_e alu_from_funct(input logic [2:0] f3, input logic alt);
    case (f3)
      3'b000:  return alt ? alu_sub : alu_add;
      3'b001:  return alu_sll;
      3'b010:  return alu_slt;
      3'b011:  return alu_sltu;
      3'b100:  return alu_xor;
      3'b101:  return alt ? alu_sra : alu_srl;
      3'b110:  return alu_or;
      default: return alu_and;
    endcase
  endfunction

  assign alt_d = inst_d.r_fmt.funct7[5];

  always_comb begin
    ctrl_d        = '0;
    ctrl_d.funct3 = inst_d.r_fmt.funct3;
    imm_sel       = imm_i;
    case (inst_d.r_fmt.opcode)
      opc_op: begin
        ctrl_d.alu_op    = alu_from_funct(inst_d.r_fmt.funct3, alt_d);
        ctrl_d.reg_write = 1'b1;
      end
      opc_op_imm: begin
        // no subi, only srai looks at the funct7 bit
        ctrl_d.alu_op      = alu_from_funct(inst_d.i_fmt.funct3,
                                            alt_d && inst_d.i_fmt.funct3 == 3'b101);
        ctrl_d.alu_src_imm = 1'b1;
        ctrl_d.reg_write   = 1'b1;
      end
      opc_lui: begin
        imm_sel            = imm_u;
        ctrl_d.alu_op      = alu_pass_b;
        ctrl_d.alu_src_imm = 1'b1;
        ctrl_d.is_lui      = 1'b1;
        ctrl_d.reg_write   = 1'b1;
      end
      opc_load: begin
        ctrl_d.alu_src_imm = 1'b1;
        ctrl_d.mem_read    = 1'b1;
        ctrl_d.reg_write   = 1'b1;
        ctrl_d.wb_from_mem = 1'b1;
      end
      opc_store: begin
        imm_sel            = imm_s;
        ctrl_d.alu_src_imm = 1'b1;
        ctrl_d.mem_write   = 1'b1;
      end
      opc_branch: begin
        imm_sel          = imm_b;
        ctrl_d.alu_op    = alu_sub;
        ctrl_d.is_branch = 1'b1;
      end
      opc_jal: begin
        imm_sel          = imm_j;
        ctrl_d.is_jal    = 1'b1;
        ctrl_d.reg_write = 1'b1;
        ctrl_d.wb_link   = 1'b1;
      end
      opc_jalr: begin
        // target comes out of the alu as rs1 + imm
        ctrl_d.alu_src_imm = 1'b1;
        ctrl_d.is_jalr     = 1'b1;
        ctrl_d.reg_write   = 1'b1;
        ctrl_d.wb_link     = 1'b1;
      end
      default: begin
        ctrl_d.funct3 = 3'b000;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n || hz.flush_e) begin
      ex_ctrl <= '0;
    end else begin
      ex_ctrl <= ctrl_d;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      mem_ctrl <= '0;
      wb_ctrl  <= '0;
    end else begin
      mem_ctrl <= '{mem_read: ex_ctrl.mem_read, mem_write: ex_ctrl.mem_write,
                    reg_write: ex_ctrl.reg_write, wb_from_mem: ex_ctrl.wb_from_mem,
                    wb_link: ex_ctrl.wb_link};
      wb_ctrl  <= '{reg_write: mem_ctrl.reg_write,
                    wb_sel: {mem_ctrl.wb_link, mem_ctrl.wb_from_mem}};
    end
  end

  assign dmem_req   = mem_ctrl.mem_read | mem_ctrl.mem_write;
  assign dmem_write = mem_ctrl.mem_write;

  // branch decision in execute
  always_comb begin
    case (ex_ctrl.funct3)
      3'b000:  taken = alu_zero;
      3'b001:  taken = !alu_zero;
      3'b100:  taken = alu_lt;
      3'b101:  taken = !alu_lt;
      3'b110:  taken = alu_ltu;
      3'b111:  taken = !alu_ltu;
      default: taken = 1'b0;
    endcase
    if (ex_ctrl.is_jalr) begin
      pc_sel = pc_jalr;
    end else if (ex_ctrl.is_jal || (ex_ctrl.is_branch && taken)) begin
      pc_sel = pc_branch_jal;
    end else begin
      pc_sel = pc_seq;
    end
  end

endmodule

// ==== rtl/datapath.sv ====
`timescale 1ns/1ps

module datapath #(
  parameter logic [31:0] reset_pc = 32'h0
) (
  input  logic                      clk,
  input  logic                      rst_n,
  output logic [cpu_pkg::xlen-1:0]  imem_addr,
  input  logic [cpu_pkg::xlen-1:0]  imem_data,
  output logic [cpu_pkg::xlen-1:0]  dmem_addr,
  output logic [cpu_pkg::xlen-1:0]  dmem_wdata,
  input  logic [cpu_pkg::xlen-1:0]  dmem_rdata,
  input  cpu_pkg::imm_sel_e         imm_sel,
  input  cpu_pkg::ex_ctrl_t         ex_ctrl,
  input  cpu_pkg::pc_sel_e          pc_sel,
  input  cpu_pkg::mem_ctrl_t        mem_ctrl,
  input  cpu_pkg::wb_ctrl_t         wb_ctrl,
  input  cpu_pkg::hazard_ctrl_t     hz,
  output cpu_pkg::inst_u            inst_d,
  output logic                      alu_zero,
  output logic                      alu_lt,
  output logic                      alu_ltu,
  output cpu_pkg::stage_regs_t      regs
);
  import cpu_pkg::*;

  logic [xlen-1:0] pc_f, pc_next;
  logic [xlen-1:0] pc_d, imm_d, rd1_d, rd2_d;
  logic [xlen-1:0] pc_e, imm_e, rd1_e, rd2_e;
  reg_addr_t       rs1_e, rs2_e, rd_e, rd_m, rd_w;
  logic [xlen-1:0] src_a, src_b_reg, src_b, alu_y, target_bj, target_jalr;
  logic [xlen-1:0] alu_m, wdata_m, pc4_m, fwd_m;
  logic [xlen-1:0] alu_w, rdata_w, pc4_w, result_w;

  function automatic logic [xlen-1:0] fwd_mux(input fwd_sel_e sel,
                                              input logic [xlen-1:0] reg_val);
    case (sel)
      fwd_from_mem: return fwd_m;
      fwd_from_wb:  return result_w;
      default:      return reg_val;
    endcase
  endfunction

  assign imem_addr = pc_f;

  // a redirect from execute wins over the load-use hold
  always_comb begin
    case (pc_sel)
      pc_branch_jal: pc_next = target_bj;
      pc_jalr:       pc_next = target_jalr;
      default:       pc_next = hz.stall_f ? pc_f : pc_f + 32'd4;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pc_f <= reset_pc;
    end else begin
      pc_f <= pc_next;
    end
  end

  // all-zero word decodes to a bubble
  always_ff @(posedge clk) begin
    if (!rst_n || hz.flush_d) begin
      inst_d <= '0;
    end else if (!hz.stall_d) begin
      inst_d <= imem_data;
    end
  end

  always_ff @(posedge clk) begin
    if (!hz.stall_d) begin
      pc_d <= pc_f;
    end
  end

  always_comb begin
    case (imm_sel)
      imm_s: imm_d = {{20{inst_d.s_fmt.imm_hi[6]}}, inst_d.s_fmt.imm_hi, inst_d.s_fmt.imm_lo};
      imm_b: imm_d = {{20{inst_d.bj_fmt.i31}}, inst_d.bj_fmt.i7, inst_d.bj_fmt.i30_25,
                      inst_d.bj_fmt.i11_8, 1'b0};
      imm_u: imm_d = {inst_d.u_fmt.imm, 12'h000};
      imm_j: imm_d = {{12{inst_d.bj_fmt.i31}}, inst_d.bj_fmt.i19_12, inst_d.bj_fmt.i20,
                      inst_d.bj_fmt.i30_25, inst_d.bj_fmt.i24_21, 1'b0};
      default: imm_d = {{20{inst_d.i_fmt.imm[11]}}, inst_d.i_fmt.imm};
    endcase
  end

  reg_file u_reg_file (
    .clk, .rst_n,
    .ra1 (inst_d.r_fmt.rs1), .ra2 (inst_d.r_fmt.rs2),
    .rd1 (rd1_d), .rd2 (rd2_d),
    .we  (wb_ctrl.reg_write), .wa (rd_w), .wd (result_w)
  );

  // decode/execute, the controller bubbles the control side
  always_ff @(posedge clk) begin
    pc_e  <= pc_d;
    imm_e <= imm_d;
    rd1_e <= rd1_d;
    rd2_e <= rd2_d;
    rs1_e <= inst_d.r_fmt.rs1;
    rs2_e <= inst_d.r_fmt.rs2;
    rd_e  <= inst_d.r_fmt.rd;
  end

  assign src_a     = fwd_mux(hz.fwd_a, rd1_e);
  assign src_b_reg = fwd_mux(hz.fwd_b, rd2_e);
  assign src_b     = ex_ctrl.alu_src_imm ? imm_e : src_b_reg;

  alu u_alu (
    .op (ex_ctrl.alu_op), .a (src_a), .b (src_b), .y (alu_y),
    .zero (alu_zero), .lt (alu_lt), .ltu (alu_ltu)
  );

  assign target_bj   = pc_e + imm_e;
  assign target_jalr = {alu_y[xlen-1:1], 1'b0};

  always_ff @(posedge clk) begin
    alu_m   <= alu_y;
    wdata_m <= src_b_reg;
    pc4_m   <= pc_e + 32'd4;
    rd_m    <= rd_e;
  end

  // jal/jalr results are the link address, not the alu output
  assign fwd_m      = mem_ctrl.wb_link ? pc4_m : alu_m;
  assign dmem_addr  = alu_m;
  assign dmem_wdata = wdata_m;

  always_ff @(posedge clk) begin
    alu_w   <= alu_m;
    rdata_w <= dmem_rdata;
    pc4_w   <= pc4_m;
    rd_w    <= rd_m;
  end

  always_comb begin
    if (wb_ctrl.wb_sel[1]) begin
      result_w = pc4_w;
    end else if (wb_ctrl.wb_sel[0]) begin
      result_w = rdata_w;
    end else begin
      result_w = alu_w;
    end
  end

  // lui carries immediate bits in the rs1 field
  assign regs = '{rs1_d: inst_d.r_fmt.rs1, rs2_d: inst_d.r_fmt.rs2,
                  rs1_e: ex_ctrl.is_lui ? 5'd0 : rs1_e, rs2_e: rs2_e,
                  rd_e: rd_e, rd_m: rd_m, rd_w: rd_w};

endmodule

// ==== rtl/reg_file.sv ====
`timescale 1ns/1ps

module reg_file (
  input  logic                      clk,
  input  logic                      rst_n,
  input  cpu_pkg::reg_addr_t        ra1,
  input  cpu_pkg::reg_addr_t        ra2,
  output logic [cpu_pkg::xlen-1:0]  rd1,
  output logic [cpu_pkg::xlen-1:0]  rd2,
  input  logic                      we,
  input  cpu_pkg::reg_addr_t        wa,
  input  logic [cpu_pkg::xlen-1:0]  wd
);
  import cpu_pkg::*;

  logic [xlen-1:0] regs [32];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (we && wa != 5'd0) begin
      regs[wa] <= wd;
    end
  end

  // writeback result is visible to decode in the same cycle
  assign rd1 = (ra1 == 5'd0) ? '0 : (we && wa == ra1) ? wd : regs[ra1];
  assign rd2 = (ra2 == 5'd0) ? '0 : (we && wa == ra2) ? wd : regs[ra2];

endmodule

// ==== rtl/alu.sv ====
`timescale 1ns/1ps

module alu (
  input  cpu_pkg::alu_op_e          op,
  input  logic [cpu_pkg::xlen-1:0]  a,
  input  logic [cpu_pkg::xlen-1:0]  b,
  output logic [cpu_pkg::xlen-1:0]  y,
  output logic                      zero,
  output logic                      lt,
  output logic                      ltu
);
  import cpu_pkg::*;

  logic [4:0] shamt;

  assign shamt = b[4:0];
  assign lt    = $signed(a) < $signed(b);
  assign ltu   = a < b;

  always_comb begin
    case (op)
      alu_add:    y = a + b;
      alu_sub:    y = a - b;
      alu_and:    y = a & b;
      alu_or:     y = a | b;
      alu_xor:    y = a ^ b;
      alu_slt:    y = {{(xlen-1){1'b0}}, lt};
      alu_sltu:   y = {{(xlen-1){1'b0}}, ltu};
      alu_sll:    y = a << shamt;
      alu_srl:    y = a >> shamt;
      alu_sra:    y = $unsigned($signed(a) >>> shamt);
      alu_pass_b: y = b;
      default:    y = '0;
    endcase
  end

  // branches run as sub, so zero means equal operands
  assign zero = (y == '0);

endmodule

// ==== rtl/cpu_pkg.sv ====
package cpu_pkg;

  localparam int xlen = 32;

  typedef logic [4:0] reg_addr_t;

  typedef enum logic [6:0] {
    opc_op     = 7'b0110011,
    opc_op_imm = 7'b0010011,
    opc_lui    = 7'b0110111,
    opc_load   = 7'b0000011,
    opc_store  = 7'b0100011,
    opc_branch = 7'b1100011,
    opc_jal    = 7'b1101111,
    opc_jalr   = 7'b1100111
  } opcode_e;

  typedef enum logic [3:0] {
    alu_add, alu_sub, alu_and, alu_or, alu_xor, alu_slt,
    alu_sltu, alu_sll, alu_srl, alu_sra, alu_pass_b
  } alu_op_e;

  typedef enum logic [2:0] {imm_i, imm_s, imm_b, imm_u, imm_j} imm_sel_e;

  typedef enum logic [1:0] {fwd_none, fwd_from_mem, fwd_from_wb} fwd_sel_e;

  typedef enum logic [1:0] {pc_seq, pc_branch_jal, pc_jalr} pc_sel_e;

  // instruction formats, one view per encoding
  typedef struct packed {
    logic [6:0] funct7;
    reg_addr_t  rs2;
    reg_addr_t  rs1;
    logic [2:0] funct3;
    reg_addr_t  rd;
    logic [6:0] opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0] imm;
    reg_addr_t   rs1;
    logic [2:0]  funct3;
    reg_addr_t   rd;
    logic [6:0]  opcode;
  } i_fmt_t;

  typedef struct packed {
    logic [6:0] imm_hi;
    reg_addr_t  rs2;
    reg_addr_t  rs1;
    logic [2:0] funct3;
    logic [4:0] imm_lo;
    logic [6:0] opcode;
  } s_fmt_t;

  typedef struct packed {
    logic [19:0] imm;
    reg_addr_t   rd;
    logic [6:0]  opcode;
  } u_fmt_t;

  // branch and jump immediates, fields named by instruction bit position
  typedef struct packed {
    logic       i31;
    logic [5:0] i30_25;
    logic [3:0] i24_21;
    logic       i20;
    logic [7:0] i19_12;
    logic [3:0] i11_8;
    logic       i7;
    logic [6:0] opcode;
  } bj_fmt_t;

  typedef union packed {
    r_fmt_t  r_fmt;
    i_fmt_t  i_fmt;
    s_fmt_t  s_fmt;
    u_fmt_t  u_fmt;
    bj_fmt_t bj_fmt;
  } inst_u;

  typedef struct packed {
    alu_op_e    alu_op;
    logic       alu_src_imm;
    logic       is_branch;
    logic [2:0] funct3;
    logic       is_jal;
    logic       is_jalr;
    logic       is_lui;
    logic       mem_read;
    logic       mem_write;
    logic       reg_write;
    logic       wb_from_mem;
    logic       wb_link;
  } ex_ctrl_t;

  typedef struct packed {
    logic mem_read;
    logic mem_write;
    logic reg_write;
    logic wb_from_mem;
    logic wb_link;
  } mem_ctrl_t;

  // wb_sel[1] picks the link address, wb_sel[0] the load data
  typedef struct packed {
    logic       reg_write;
    logic [1:0] wb_sel;
  } wb_ctrl_t;

  typedef struct packed {
    fwd_sel_e fwd_a;
    fwd_sel_e fwd_b;
    logic     stall_f;
    logic     stall_d;
    logic     flush_d;
    logic     flush_e;
  } hazard_ctrl_t;

  typedef struct packed {
    reg_addr_t rs1_d;
    reg_addr_t rs2_d;
    reg_addr_t rs1_e;
    reg_addr_t rs2_e;
    reg_addr_t rd_e;
    reg_addr_t rd_m;
    reg_addr_t rd_w;
  } stage_regs_t;

  typedef struct packed {
    logic [xlen-1:0] addr;
    logic [xlen-1:0] wdata;
    logic            req;
    logic            write;
  } dmem_req_t;

endpackage
